/* queen_pkg.sv */
package queen_pkg;

    // largest board side the types can hold
    localparam int MAX_BOARD = 16;

    // row or column index
    typedef logic [$clog2(MAX_BOARD)-1:0] coord_t;

    // one bit per row, or one bit per column
    // bits at the board side and above stay zero
    typedef logic [MAX_BOARD-1:0] row_mask_t;

    // search FSM
    //   S_IDLE  waiting for a burst
    //   S_LOAD  burst in progress
    //   S_PLACE one column per cycle
    //   S_BACK  one column back per cycle
    //   S_EMIT  solution being streamed
    typedef enum logic [2:0] {
        S_IDLE  = 3'd0,
        S_LOAD  = 3'd1,
        S_PLACE = 3'd2,
        S_BACK  = 3'd3,
        S_EMIT  = 3'd4
    } search_state_t;

endpackage

/* queen_input.sv */
`timescale 1ns/100ps

module queen_input import queen_pkg::*; #(
    parameter int BOARD_N = 12
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  coord_t                   row,
    input  coord_t                   col,
    input  logic                     accepting,
    output row_mask_t                fixed_mask,
    output coord_t [BOARD_N-1:0]     fixed_rows
);

    logic in_valid_q;
    logic wr_en;
    logic first_beat;

    assign wr_en      = in_valid && accepting;
    // a beat with no beat before it opens a new burst
    assign first_beat = wr_en && !in_valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_valid_q <= 1'b0;
            fixed_mask <= '0;
        end else begin
            in_valid_q <= in_valid;
            if (wr_en) begin
                fixed_mask <= (first_beat ? row_mask_t'('0) : fixed_mask) |
                              (row_mask_t'(1) << col);
            end
        end
    end

    // row per column
    // a later pair for the same column overwrites
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int c = 0; c < BOARD_N; c++) begin
                if (coord_t'(c) == col) begin
                    fixed_rows[c] <= row;
                end else if (first_beat) begin
                    fixed_rows[c] <= '0;
                end
            end
        end
    end

    a_coord_range: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> (row < BOARD_N) && (col < BOARD_N))
        else $error("fixed queen outside the board");

    a_burst_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_valid) |-> accepting)
        else $error("burst started while the solver was busy");

endmodule

/* queen_attack.sv */
`timescale 1ns/100ps

module queen_attack import queen_pkg::*; #(
    parameter int BOARD_N = 12
) (
    input  coord_t                   col_sel,
    input  coord_t [BOARD_N-1:0]     placed_rows,
    input  row_mask_t                placed_mask,
    output row_mask_t                free_rows
);

    // queen at (qr, qc) covers square (r, c) on its row or a diagonal
    function automatic logic attacks(
        input coord_t qr,
        input coord_t qc,
        input coord_t r,
        input coord_t c
    );
        coord_t dr;
        coord_t dc;
        dr = (qr > r) ? coord_t'(qr - r) : coord_t'(r - qr);
        dc = (qc > c) ? coord_t'(qc - c) : coord_t'(c - qc);
        return (qr == r) || (dr == dc);
    endfunction

    always_comb begin
        // rows past the board side stay blocked
        free_rows = '0;
        for (int r = 0; r < BOARD_N; r++) begin
            free_rows[r] = 1'b1;
            for (int c = 0; c < BOARD_N; c++) begin
                if (placed_mask[c] &&
                    attacks(placed_rows[c], coord_t'(c), coord_t'(r), col_sel)) begin
                    free_rows[r] = 1'b0;
                end
            end
        end
    end

endmodule

/* queen_search.sv */
`timescale 1ns/100ps

module queen_search import queen_pkg::*; #(
    parameter int BOARD_N = 12
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  row_mask_t                fixed_mask,
    input  coord_t [BOARD_N-1:0]     fixed_rows,
    input  row_mask_t                free_rows,
    input  logic                     emit_done,
    output logic                     accepting,
    output logic                     busy,
    output coord_t                   col_sel,
    output coord_t [BOARD_N-1:0]     placed_rows,
    output row_mask_t                placed_mask,
    output logic                     solved,
    output logic                     no_solution
);

    search_state_t state_q;
    coord_t        col_q;
    coord_t        start_q;
    coord_t        prev_col;
    row_mask_t     cand_rows;
    coord_t        pick_row;
    logic          col_fixed;
    logic          last_col;
    logic          place_ok;
    coord_t        place_row;

    assign col_sel   = col_q;
    assign prev_col  = col_q - coord_t'(1);
    assign col_fixed = fixed_mask[col_q];
    assign last_col  = (col_q == coord_t'(BOARD_N - 1));

    // free rows of an open column at or above the retry point
    assign cand_rows = free_rows & (row_mask_t'('1) << start_q);

    // lowest set bit wins
    always_comb begin
        pick_row = '0;
        for (int r = BOARD_N - 1; r >= 0; r--) begin
            if (cand_rows[r]) begin
                pick_row = coord_t'(r);
            end
        end
    end

    assign place_ok  = col_fixed ? free_rows[fixed_rows[col_q]] : |cand_rows;
    assign place_row = col_fixed ? fixed_rows[col_q] : pick_row;

    assign accepting   = (state_q == S_IDLE) || (state_q == S_LOAD);
    assign busy        = (state_q != S_IDLE);
    assign solved      = (state_q == S_PLACE) && place_ok && last_col;
    // nothing left below column 0 to retry
    assign no_solution = (state_q == S_BACK) && (col_q == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= S_IDLE;
            col_q       <= '0;
            start_q     <= '0;
            placed_mask <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (in_valid) begin
                        state_q <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    if (!in_valid) begin
                        state_q     <= S_PLACE;
                        col_q       <= '0;
                        start_q     <= '0;
                        placed_mask <= '0;
                    end
                end
                S_PLACE: begin
                    if (place_ok) begin
                        placed_mask[col_q] <= 1'b1;
                        start_q            <= '0;
                        if (last_col) begin
                            state_q <= S_EMIT;
                        end else begin
                            col_q <= col_q + coord_t'(1);
                        end
                    end else begin
                        state_q <= S_BACK;
                    end
                end
                S_BACK: begin
                    if (col_q == '0) begin
                        state_q <= S_IDLE;
                    end else begin
                        // fixed columns are stepped over and open ones get the next row
                        col_q                 <= prev_col;
                        placed_mask[prev_col] <= 1'b0;
                        if (!fixed_mask[prev_col]) begin
                            start_q <= placed_rows[prev_col] + coord_t'(1);
                            state_q <= S_PLACE;
                        end
                    end
                end
                S_EMIT: begin
                    if (emit_done) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_PLACE && place_ok) begin
            placed_rows[col_q] <= place_row;
        end
    end

    a_one_result: assert property (@(posedge clk) disable iff (!rst_n)
        !(solved && no_solution))
        else $error("solved and no_solution raised together");

    a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q != S_IDLE) |-> (col_sel < BOARD_N))
        else $error("column pointer left the board in state %s", state_q.name());

endmodule

/* queen_output.sv */
`timescale 1ns/100ps

module queen_output import queen_pkg::*; #(
    parameter int BOARD_N = 12
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     solved,
    input  coord_t [BOARD_N-1:0]     placed_rows,
    output logic                     out_valid,
    output coord_t                   out,
    output logic                     emit_done
);

    logic   active_q;
    coord_t cnt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
        end else if (solved) begin
            active_q <= 1'b1;
            cnt_q    <= '0;
        end else if (active_q) begin
            if (emit_done) begin
                active_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q + coord_t'(1);
            end
        end
    end

    // rows go out in column order and read zero between solutions
    assign out_valid = active_q;
    assign out       = active_q ? placed_rows[cnt_q] : '0;
    assign emit_done = active_q && (cnt_q == coord_t'(BOARD_N - 1));

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        solved |-> !active_q)
        else $error("new solution arrived while still streaming");

endmodule

/* queen_top.sv */
`timescale 1ns/100ps

module queen_top import queen_pkg::*; #(
    parameter int BOARD_N = 12
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  coord_t row,
    input  coord_t col,
    output logic   busy,
    output logic   out_valid,
    output coord_t out,
    output logic   no_solution
);

    logic                 accepting;
    row_mask_t            fixed_mask;
    coord_t [BOARD_N-1:0] fixed_rows;
    coord_t               col_sel;
    coord_t [BOARD_N-1:0] placed_rows;
    row_mask_t            placed_mask;
    row_mask_t            free_rows;
    logic                 solved;
    logic                 emit_done;

    queen_input #(.BOARD_N(BOARD_N)) u_queen_input (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .row        (row),
        .col        (col),
        .accepting  (accepting),
        .fixed_mask (fixed_mask),
        .fixed_rows (fixed_rows)
    );

    queen_attack #(.BOARD_N(BOARD_N)) u_queen_attack (
        .col_sel     (col_sel),
        .placed_rows (placed_rows),
        .placed_mask (placed_mask),
        .free_rows   (free_rows)
    );

    queen_search #(.BOARD_N(BOARD_N)) u_queen_search (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .fixed_mask  (fixed_mask),
        .fixed_rows  (fixed_rows),
        .free_rows   (free_rows),
        .emit_done   (emit_done),
        .accepting   (accepting),
        .busy        (busy),
        .col_sel     (col_sel),
        .placed_rows (placed_rows),
        .placed_mask (placed_mask),
        .solved      (solved),
        .no_solution (no_solution)
    );

    queen_output #(.BOARD_N(BOARD_N)) u_queen_output (
        .clk         (clk),
        .rst_n       (rst_n),
        .solved      (solved),
        .placed_rows (placed_rows),
        .out_valid   (out_valid),
        .out         (out),
        .emit_done   (emit_done)
    );

endmodule

/* tb_queen_clock.sv */
`timescale 1ns/100ps

module tb_queen_clock #(
    parameter real PERIOD = 4.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2.0) clk = ~clk;

endmodule

/* tb_queen.sv */
`timescale 1ns/100ps

module tb_queen import queen_pkg::*;;

    localparam int N         = 12;
    localparam int NUM_CASES = 6;
    localparam int LIMIT     = NUM_CASES * 200000;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    coord_t row;
    coord_t col;
    logic   busy;
    logic   out_valid;
    coord_t out;
    logic   no_solution;

    int     value_errors = 0;
    int     other_errors = 0;
    int     cycles = 0;
    bit     fix_on[N];
    int     fix_row[N];
    int     exp_rows[N];
    int     got_rows[N];
    bit     exp_found;
    int     burst_rows[$];
    int     burst_cols[$];

    tb_queen_clock #(.PERIOD(4.0)) u_clock (.clk(clk));

    queen_top #(.BOARD_N(N)) u_queen_top (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .row(row), .col(col),
        .busy(busy), .out_valid(out_valid), .out(out), .no_solution(no_solution)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("run stopped after %0d cycles, solver stuck in state %s",
                     cycles, u_queen_top.u_queen_search.state_q.name());
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // output must be quiet between results
    always @(negedge clk) begin
        if (rst_n) begin
            assert (out_valid || out == '0) else begin
                value_errors++;
                $display("** Error at %0t: out expected 0, got %0d", $time, out);
            end
            assert (!(out_valid && no_solution)) else begin
                other_errors++;
                $display("out_valid and no_solution were high together at %0t", $time);
            end
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            value_errors++;
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    function automatic bit row_free(input int c, input int r);
        for (int k = 0; k < c; k++) begin
            if (exp_rows[k] == r || exp_rows[k] - r == k - c || exp_rows[k] - r == c - k) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // column by column with the lowest row first and a retry at the nearest open column
    task automatic model_solve();
        int  c;
        int  start;
        bit  done;
        bit  placed;
        c = 0;
        start = 0;
        done = 0;
        exp_found = 0;
        while (!done) begin
            if (c == N) begin
                exp_found = 1;
                done = 1;
            end else begin
                placed = 0;
                if (fix_on[c]) begin
                    if (row_free(c, fix_row[c])) begin
                        exp_rows[c] = fix_row[c];
                        placed = 1;
                    end
                end else begin
                    for (int r = start; r < N && !placed; r++) begin
                        if (row_free(c, r)) begin
                            exp_rows[c] = r;
                            placed = 1;
                        end
                    end
                end
                if (placed) begin
                    c++;
                    start = 0;
                end else begin
                    c--;
                    while (c >= 0 && fix_on[c]) c--;
                    if (c < 0) done = 1;
                    else start = exp_rows[c] + 1;
                end
            end
        end
    endtask

    function automatic bit compatible(input int r, input int c);
        if (fix_on[c]) return 1'b0;
        foreach (burst_cols[i]) begin
            if (burst_rows[i] == r || burst_rows[i] - r == burst_cols[i] - c ||
                burst_rows[i] - r == c - burst_cols[i]) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic build_random(input int count);
        int r;
        int c;
        burst_rows.delete();
        burst_cols.delete();
        foreach (fix_on[i]) fix_on[i] = 0;
        while (burst_cols.size() < count) begin
            r = $urandom % N;
            c = $urandom % N;
            if (compatible(r, c)) begin
                burst_rows.push_back(r);
                burst_cols.push_back(c);
                fix_on[c] = 1;
            end
        end
    endtask

    task automatic run_case();
        foreach (fix_on[i]) fix_on[i] = 0;
        foreach (burst_cols[i]) begin
            fix_on[burst_cols[i]] = 1;
            fix_row[burst_cols[i]] = burst_rows[i];
        end
        model_solve();
        foreach (burst_cols[i]) begin
            @(posedge clk);
            #1 in_valid = 1'b1;
            row = coord_t'(burst_rows[i]);
            col = coord_t'(burst_cols[i]);
            // busy follows the first beat by one cycle
            @(negedge clk);
            check_value("busy", i > 0, busy);
        end
        @(posedge clk);
        #1 in_valid = 1'b0;
        row = '0;
        col = '0;
        @(negedge clk);
        check_value("busy", 1, busy);
        while (!out_valid && !no_solution) begin
            assert (busy) else begin
                other_errors++;
                $display("busy dropped at %0t before any result", $time);
            end
            @(negedge clk);
        end
        check_value("no_solution", !exp_found, no_solution);
        if (out_valid) begin
            for (int c = 0; c < N; c++) begin
                check_value("out_valid", 1, out_valid);
                check_value("out", exp_rows[c], out);
                got_rows[c] = out;
                @(negedge clk);
            end
            foreach (burst_cols[i]) check_value("fixed row", burst_rows[i], got_rows[burst_cols[i]]);
            for (int a = 0; a < N; a++) begin
                for (int b = a + 1; b < N; b++) begin
                    assert (got_rows[a] != got_rows[b] && got_rows[a] - got_rows[b] != a - b &&
                            got_rows[a] - got_rows[b] != b - a) else begin
                        other_errors++;
                        $display("columns %0d and %0d attack each other", a, b);
                    end
                end
            end
        end else begin
            @(negedge clk);
        end
        check_value("out_valid", 0, out_valid);
        check_value("no_solution", 0, no_solution);
        check_value("busy", 0, busy);
    endtask

    initial begin
        int r;
        void'($urandom(32'h7460));
        rst_n = 1'b0;
        in_valid = 1'b0;
        row = '0;
        col = '0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("busy", 0, busy);
            check_value("out_valid", 0, out_valid);
            check_value("no_solution", 0, no_solution);
            check_value("out", 0, out);
        end
        build_random(1);
        run_case();
        for (int k = 0; k < 3; k++) begin
            build_random(2 + k % 2);
            run_case();
        end
        // conflicting pair in the first two columns
        r = $urandom % (N - 1);
        burst_rows = '{r, ($urandom % 2) ? r : r + 1};
        burst_cols = '{0, 1};
        run_case();
        // back to back burst right after busy fell
        build_random(3);
        run_case();
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
queen_pkg.sv
queen_input.sv
queen_attack.sv
queen_search.sv
queen_output.sv
queen_top.sv
tb_queen_clock.sv
tb_queen.sv

/* Bender.yml */
package:
  name: queen

sources:
  - files:
      - queen_pkg.sv
      - queen_input.sv
      - queen_attack.sv
      - queen_search.sv
      - queen_output.sv
      - queen_top.sv
  - target: test
    files:
      - tb_queen_clock.sv
      - tb_queen.sv
